/* Bender.yml */
package:
  name: anneal_top

sources:
  - include_dirs:
      - design
    files:
      - design/replica_pkg.sv
      - design/command_pkg.sv
      - design/chain_ctrl_if.sv
      - design/reg_bus.sv
      - design/node_control.sv
      - design/replica_node.sv
      - design/anneal_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/tb_anneal_top.sv

/* design/anneal_defines.svh */
`ifndef ANNEAL_DEFINES_SVH
`define ANNEAL_DEFINES_SVH

// chain size
`define REPLICA_NUM 8

// record fields
`define ENERGY_W 16
`define TAG_W 8

// exchange round counter
`define RUN_W 16

// host register map
`define ADDR_RUN 0
`define ADDR_SHIFT 1
`define DATA_W 32

`endif

/* design/anneal_top.sv */
`timescale 1ns/1ps
`include "anneal_defines.svh"

module anneal_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  command_pkg::reg_addr_t wr_addr,
    input  logic [`DATA_W-1:0]     wr_data,
    input  command_pkg::reg_addr_t rd_addr,
    output logic [`DATA_W-1:0]     rd_data
);
    import replica_pkg::*;

    logic              run_write;
    logic [`RUN_W-1:0] run_times;
    logic              running;
    logic [`RUN_W-1:0] rounds_done;

    // node g reads [g] and [g+2], drives [g+1]
    replica_data_t [`REPLICA_NUM+1:0] node_data;
    logic          [`REPLICA_NUM:0]   node_exchange;

    chain_ctrl_if chain ();

    assign node_data[0]              = '0;
    assign node_data[`REPLICA_NUM+1] = '0; // no follower past the tail
    assign node_exchange[0]          = 1'b0;

    reg_bus reg_bus (
        .clk         ( clk                     ),
        .reset       ( reset                   ),
        .wr_en       ( wr_en                   ),
        .wr_addr     ( wr_addr                 ),
        .wr_data     ( wr_data                 ),
        .rd_addr     ( rd_addr                 ),
        .rd_data     ( rd_data                 ),
        .tail_data   ( node_data[`REPLICA_NUM] ),
        .run_write   ( run_write               ),
        .run_times   ( run_times               ),
        .running     ( running                 ),
        .rounds_done ( rounds_done             ),
        .chain       ( chain                   )
    );

    node_control node_control (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .run_write   ( run_write   ),
        .run_times   ( run_times   ),
        .running     ( running     ),
        .rounds_done ( rounds_done ),
        .chain       ( chain       )
    );

    for (genvar g = 0; g < `REPLICA_NUM; g += 1) begin : gen_node
        replica_node #(.id(g)) node (
            .clk           ( clk                  ),
            .reset         ( reset                ),
            .chain         ( chain                ),
            .prev_data     ( node_data[g]         ),
            .folw_data     ( node_data[g+2]       ),
            .out_data      ( node_data[g+1]       ),
            .prev_exchange ( node_exchange[g]     ),
            .out_exchange  ( node_exchange[g+1]   )
        );
    end

endmodule

/* design/chain_ctrl_if.sv */
`timescale 1ns/1ps

interface chain_ctrl_if;
    import replica_pkg::*;
    import command_pkg::*;

    logic          shift;         // move every record one node on
    replica_data_t shift_data;    // record entering node 0
    logic          exchange_run;  // one exchange round this cycle
    round_bank_t   exchange_bank; // pair phase of that round

    modport regs (
        output shift,
        output shift_data
    );

    modport ctrl (
        output exchange_run,
        output exchange_bank
    );

    modport node (
        input shift,
        input shift_data,
        input exchange_run,
        input exchange_bank
    );

endinterface

/* design/command_pkg.sv */
`include "anneal_defines.svh"

package command_pkg;

    // which nodes open a pair in the current round
    typedef enum logic {
        BANK_EVEN = 1'b0,
        BANK_ODD  = 1'b1
    } round_bank_t;

    typedef enum logic {
        REG_RUN   = 1'(`ADDR_RUN),
        REG_SHIFT = 1'(`ADDR_SHIFT)
    } reg_addr_t;

    // status word seen by the host
    typedef struct packed {
        logic              running;
        logic [`RUN_W-1:0] rounds_done;
    } status_t;

endpackage

/* design/node_control.sv */
`timescale 1ns/1ps
`include "anneal_defines.svh"

module node_control (
    input  logic              clk,
    input  logic              reset,
    input  logic              run_write,
    input  logic [`RUN_W-1:0] run_times,
    output logic              running,
    output logic [`RUN_W-1:0] rounds_done,
    chain_ctrl_if.ctrl        chain
);
    import command_pkg::*;

    logic [`RUN_W-1:0] round_target;
    logic              last_round;

    assign chain.exchange_run = running; // one round per cycle
    assign last_round = (rounds_done + `RUN_W'd1) == round_target;

    always_ff @(posedge clk) begin
        if (run_write) begin
            round_target <= run_times;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running             <= 1'b0;
            rounds_done         <= '0;
            chain.exchange_bank <= BANK_EVEN;
        end else if (run_write) begin
            running             <= run_times != '0; // zero rounds never starts
            rounds_done         <= '0;
            chain.exchange_bank <= BANK_EVEN;
        end else if (running) begin
            rounds_done <= rounds_done + `RUN_W'd1;
            if (last_round) begin
                running             <= 1'b0;
                chain.exchange_bank <= BANK_EVEN; // park for the next start
            end else if (chain.exchange_bank == BANK_EVEN) begin
                chain.exchange_bank <= BANK_ODD;
            end else begin
                chain.exchange_bank <= BANK_EVEN;
            end
        end
    end

    // rounds only happen while the count is still short of the target
    assert property (@(posedge clk) disable iff (reset)
        chain.exchange_run |-> rounds_done < round_target)
        else $error("exchange round outside a run");

    assert property (@(posedge clk) disable iff (reset)
        $changed(chain.exchange_bank) |-> $past(chain.exchange_run))
        else $error("pair phase changed without an exchange round");

endmodule

/* design/reg_bus.sv */
`timescale 1ns/1ps
`include "anneal_defines.svh"

module reg_bus (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_en,
    input  command_pkg::reg_addr_t     wr_addr,
    input  logic [`DATA_W-1:0]         wr_data,
    input  command_pkg::reg_addr_t     rd_addr,
    output logic [`DATA_W-1:0]         rd_data,
    input  replica_pkg::replica_data_t tail_data,
    output logic                       run_write,
    output logic [`RUN_W-1:0]          run_times,
    input  logic                       running,
    input  logic [`RUN_W-1:0]          rounds_done,
    chain_ctrl_if.regs                 chain
);
    import replica_pkg::*;
    import command_pkg::*;

    logic    busy;
    logic    shift_wr;
    logic    run_wr;
    status_t status;

    assign busy     = running | run_write; // a pending start counts too
    assign shift_wr = wr_en && wr_addr == REG_SHIFT && !busy;
    assign run_wr   = wr_en && wr_addr == REG_RUN && !busy;

    assign status.running     = running;
    assign status.rounds_done = rounds_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            chain.shift <= 1'b0;
            run_write   <= 1'b0;
        end else begin
            chain.shift <= shift_wr; // nodes move on the next edge
            run_write   <= run_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_wr) begin
            chain.shift_data <= replica_data_t'(wr_data[$bits(replica_data_t)-1:0]);
        end
        if (run_wr) begin
            run_times <= wr_data[`RUN_W-1:0];
        end
    end

    always_comb begin
        rd_data = '0;
        case (rd_addr)
            REG_RUN:   rd_data[$bits(status_t)-1:0] = status;
            REG_SHIFT: rd_data[$bits(replica_data_t)-1:0] = tail_data; // last node
            default:   rd_data = '0;
        endcase
    end

    // a shift accepted before a start must never land inside a run
    assert property (@(posedge clk) disable iff (reset)
        chain.shift |-> !running)
        else $error("shift pulse while exchange rounds are running");

endmodule

/* design/replica_node.sv */
`timescale 1ns/1ps
`include "anneal_defines.svh"

module replica_node #(
    parameter int id = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    chain_ctrl_if.node                 chain,
    input  replica_pkg::replica_data_t prev_data,
    input  replica_pkg::replica_data_t folw_data,
    output replica_pkg::replica_data_t out_data,
    input  logic                       prev_exchange,
    output logic                       out_exchange
);
    import command_pkg::*;

    // last node has nobody to pair with on its right
    localparam bit has_folw = id < `REPLICA_NUM - 1;
    localparam round_bank_t pair_bank = (id % 2 == 0) ? BANK_EVEN : BANK_ODD;

    logic pair_left;

    assign pair_left = has_folw && chain.exchange_bank == pair_bank;

    // left node decides, right node only follows
    assign out_exchange = chain.exchange_run && pair_left
                          && out_data.energy > folw_data.energy;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_data <= '0;
        end else if (chain.shift) begin
            if (id == 0) begin
                out_data <= chain.shift_data; // chain entry
            end else begin
                out_data <= prev_data;
            end
        end else if (out_exchange) begin
            out_data <= folw_data; // take the lower energy
        end else if (chain.exchange_run && prev_exchange) begin
            out_data <= prev_data;
        end
    end

    // host shifts and controller rounds come from different blocks
    assert property (@(posedge clk) disable iff (reset)
        !(chain.shift && chain.exchange_run))
        else $error("shift and exchange round in the same cycle");

endmodule

/* design/replica_pkg.sv */
`include "anneal_defines.svh"

package replica_pkg;

    // one replica record as it moves along the chain
    typedef struct packed {
        logic [`ENERGY_W-1:0] energy; // total tour distance
        logic [`TAG_W-1:0]    tag;    // ordering index
    } replica_data_t;

endpackage

/* sim.f */
+incdir+design
design/replica_pkg.sv
design/command_pkg.sv
design/chain_ctrl_if.sv
design/reg_bus.sv
design/node_control.sv
design/replica_node.sv
design/anneal_top.sv
verification/tb_anneal_top.sv

/* verification/tb_anneal_top.sv */
`timescale 1ns/1ps
`include "anneal_defines.svh"

module tb_anneal_top;
    import replica_pkg::*;
    import command_pkg::*;

    localparam int N         = `REPLICA_NUM;
    localparam int SHIFT_CYC = 2;         // write cycle plus move cycle
    localparam int RUN_CYC   = 3 * N + 4; // longest run plus start and poll
    localparam int RUNS4     = 8;
    localparam int TOTAL_CYC = 8 + SHIFT_CYC * N * (2 + 2 + RUNS4 + 1 + 1)
                               + RUN_CYC * (1 + RUNS4 + 1 + 2);

    logic               clk;
    logic               reset;
    logic               wr_en;
    reg_addr_t          wr_addr;
    logic [`DATA_W-1:0] wr_data;
    reg_addr_t          rd_addr;
    logic [`DATA_W-1:0] rd_data;

    integer        seed;
    replica_data_t model [N]; // expected chain contents, node 0 first

    anneal_top uut (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .wr_en   ( wr_en   ),
        .wr_addr ( wr_addr ),
        .wr_data ( wr_data ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(TOTAL_CYC * 2 * 40);
        $display("Something failed");
        $fatal(1, "run timed out before all tests finished");
    end

    task automatic check_value(input string name, input logic [`DATA_W-1:0] expected,
                               input logic [`DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic replica_data_t random_record();
        replica_data_t rec;
        rec.energy = $random(seed);
        rec.tag    = $random(seed);
        return rec;
    endfunction

    function automatic void apply_shift(input replica_data_t rec);
        for (int i = N - 1; i > 0; i--) begin
            model[i] = model[i-1];
        end
        model[0] = rec;
    endfunction

    // one odd-even transposition pass starting at node first
    function automatic void exchange_pairs(input int first);
        replica_data_t tmp;
        for (int i = first; i < N - 1; i += 2) begin
            if (model[i].energy > model[i+1].energy) begin
                tmp        = model[i];
                model[i]   = model[i+1];
                model[i+1] = tmp;
            end
        end
    endfunction

    task automatic read_reg(input reg_addr_t addr, output logic [`DATA_W-1:0] data);
        rd_addr = addr;
        #1; // read mux is combinational
        data = rd_data;
    endtask

    task automatic shift_record(input string name, input replica_data_t rec,
                                output logic [`DATA_W-1:0] tail);
        read_reg(REG_SHIFT, tail);
        check_value(name, `DATA_W'(model[N-1]), tail);
        wr_en   = 1'b1;
        wr_addr = REG_SHIFT;
        wr_data = `DATA_W'(rec);
        @(negedge clk);
        wr_en = 1'b0;
        @(negedge clk); // chain has moved by now
        apply_shift(rec);
    endtask

    task automatic shift_many(input string name, input int count, input bit sorted);
        logic [`DATA_W-1:0]   tail;
        logic [`ENERGY_W-1:0] prev_energy;
        replica_data_t        tail_rec;
        prev_energy = '1;
        for (int i = 0; i < count; i++) begin
            shift_record(name, random_record(), tail);
            tail_rec = replica_data_t'(tail[$bits(replica_data_t)-1:0]);
            if (sorted) begin
                // tail comes out first, so energies fall
                check_value($sformatf("%s order", name), 1, tail_rec.energy <= prev_energy);
                prev_energy = tail_rec.energy;
            end
        end
    endtask

    task automatic run_rounds(input string name, input int n, input bit poke);
        logic [`DATA_W-1:0] data;
        status_t            st;
        wr_en   = 1'b1;
        wr_addr = REG_RUN;
        wr_data = n;
        @(negedge clk);
        wr_en = 1'b0;
        @(negedge clk);
        read_reg(REG_RUN, data);
        st = status_t'(data[$bits(status_t)-1:0]);
        check_value($sformatf("%s start", name), n != 0, st.running);
        check_value($sformatf("%s start count", name), 0, st.rounds_done);
        while (st.running) begin
            if (poke) begin
                wr_en   = 1'b1; // must be dropped by the DUT
                wr_addr = REG_SHIFT;
                wr_data = `DATA_W'(random_record());
            end
            @(negedge clk);
            wr_en = 1'b0;
            read_reg(REG_RUN, data);
            st = status_t'(data[$bits(status_t)-1:0]);
        end
        check_value($sformatf("%s rounds", name), n, st.rounds_done);
        for (int r = 0; r < n; r++) begin
            exchange_pairs(r % 2);
        end
    endtask

    initial begin
        logic [`DATA_W-1:0] data;
        int                 n;
        seed    = 32'hd3bf;
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = REG_RUN;
        wr_data = '0;
        rd_addr = REG_RUN;
        for (int i = 0; i < N; i++) begin
            model[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        read_reg(REG_RUN, data);
        check_value("reset status", 0, data);
        read_reg(REG_SHIFT, data);
        check_value("reset tail", 0, data);

        for (int i = 0; i < 2 * N; i++) begin
            shift_record("shift round trip", random_record(), data);
            if (i < N) begin
                check_value("shift empty chain", 0, data);
            end
        end

        shift_many("single round load", N, 1'b0);
        run_rounds("single round", 1, 1'b0);
        shift_many("single round unload", N, 1'b0);

        for (int k = 0; k < RUNS4; k++) begin
            n = {$random(seed)} % (3 * N) + 1;
            run_rounds("random rounds", n, 1'b0);
            shift_many("random rounds unload", N, n >= N);
        end

        run_rounds("shift while running", 2 * N, 1'b1);
        shift_many("shift while running unload", N, 1'b1);

        run_rounds("status running", 5, 1'b0);
        shift_many("status running unload", N, 1'b0);
        run_rounds("zero run", 0, 1'b0);

        $display("Everything OK");
        $finish;
    end

endmodule
